/* hdl/rv_pkg.sv */
package rv_pkg;

   localparam int XLEN = 64;

   typedef logic [XLEN-1:0] xlen_t;
   typedef logic [31:0]     insn_t;
   typedef logic [4:0]      reg_addr_t;
   typedef logic [3:0]      alu_op_t;
   typedef logic [2:0]      opb_sel_t;
   typedef logic [3:0]      lsu_size_t;    // Byte count of one access.
   typedef logic [7:0]      dmem_addr_t;

   localparam alu_op_t ALU_OP_ADD   = 4'd0;
   localparam alu_op_t ALU_OP_SUB   = 4'd1;
   localparam alu_op_t ALU_OP_SLL   = 4'd2;
   localparam alu_op_t ALU_OP_SLT   = 4'd3;
   localparam alu_op_t ALU_OP_SLTU  = 4'd4;
   localparam alu_op_t ALU_OP_XOR   = 4'd5;
   localparam alu_op_t ALU_OP_SRL   = 4'd6;
   localparam alu_op_t ALU_OP_SRA   = 4'd7;
   localparam alu_op_t ALU_OP_OR    = 4'd8;
   localparam alu_op_t ALU_OP_AND   = 4'd9;
   localparam alu_op_t ALU_OP_PASSB = 4'd10;  // Operand B straight through for LUI.

   localparam opb_sel_t OPB_RF    = 3'd0;
   localparam opb_sel_t OPB_IMM12 = 3'd1;
   localparam opb_sel_t OPB_IMM20 = 3'd2;
   localparam opb_sel_t OPB_SHAMT = 3'd3;

   localparam int DMEM_BYTES = 256;

   localparam logic [6:0] OPC_LUI      = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
   localparam logic [6:0] OPC_JAL      = 7'b1101111;
   localparam logic [6:0] OPC_JALR     = 7'b1100111;
   localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
   localparam logic [6:0] OPC_LOAD     = 7'b0000011;
   localparam logic [6:0] OPC_STORE    = 7'b0100011;
   localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
   localparam logic [6:0] OPC_OP       = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
   localparam logic [6:0] OPC_OP32     = 7'b0111011;

   typedef enum logic [1:0] {
      IDLE,
      EXEC,
      ACK
   } exu_state_t;

endpackage

/* hdl/rv_idu.sv */
`timescale 1ns/1ps

module rv_idu (
   input  rv_pkg::insn_t     i_insn,
   output rv_pkg::reg_addr_t o_rs1_addr,
   output rv_pkg::reg_addr_t o_rs2_addr,
   output rv_pkg::reg_addr_t o_rd,
   output logic              o_rf_we,
   output logic              o_illegal,
   output rv_pkg::alu_op_t   o_alu_op,
   output rv_pkg::opb_sel_t  o_opb_sel,
   output logic              o_opa_pc,
   output logic              o_word,
   output logic              o_lsu_load,
   output logic              o_lsu_store,
   output logic              o_lsu_sigext,
   output rv_pkg::lsu_size_t o_lsu_size,
   output logic              o_branch,
   output logic [2:0]        o_br_cond,
   output logic              o_jal,
   output logic              o_jalr,
   output logic [11:0]       o_imm12,
   output logic [12:0]       o_imm13,
   output logic [20:0]       o_imm21,
   output logic [19:0]       o_imm20,
   output logic [5:0]        o_shamt
);
   import rv_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       alt7;
   logic       imm_ok;
   logic       imm32_ok;
   logic       reg_ok;
   logic       reg32_ok;
   logic       is_lui;
   logic       is_auipc;
   logic       is_jal;
   logic       is_jalr;
   logic       is_branch;
   logic       is_load;
   logic       is_store;
   logic       is_op_imm;
   logic       is_op;
   logic       is_op_imm32;
   logic       is_op32;
   logic       is_arith;
   logic       illegal;

   assign opcode = i_insn[6:0];
   assign funct3 = i_insn[14:12];
   assign funct7 = i_insn[31:25];
   assign alt7   = (funct7 == 7'b0100000);

   // RV64 immediate shifts have a six-bit shamt, so only insn[31:26] names the shift kind.
   assign imm_ok = (funct3 == 3'b001) ? (i_insn[31:26] == 6'b000000) :
                   (funct3 == 3'b101) ? (i_insn[31:26] == 6'b000000) ||
                                        (i_insn[31:26] == 6'b010000) : 1'b1;
   assign imm32_ok = (funct3 == 3'b000) ||
                     ((funct3 == 3'b001) && (funct7 == 7'b0)) ||
                     ((funct3 == 3'b101) && ((funct7 == 7'b0) || alt7));
   assign reg_ok   = (funct7 == 7'b0) || (alt7 && ((funct3 == 3'b000) || (funct3 == 3'b101)));
   assign reg32_ok = reg_ok && ((funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101));

   assign is_lui      = (opcode == OPC_LUI);
   assign is_auipc    = (opcode == OPC_AUIPC);
   assign is_jal      = (opcode == OPC_JAL);
   assign is_jalr     = (opcode == OPC_JALR) && (funct3 == 3'b000);
   assign is_branch   = (opcode == OPC_BRANCH) && (funct3[2:1] != 2'b01);
   assign is_load     = (opcode == OPC_LOAD) && (funct3 != 3'b111);
   assign is_store    = (opcode == OPC_STORE) && !funct3[2];
   assign is_op_imm   = (opcode == OPC_OP_IMM) && imm_ok;
   assign is_op       = (opcode == OPC_OP) && reg_ok;
   assign is_op_imm32 = (opcode == OPC_OP_IMM32) && imm32_ok;
   assign is_op32     = (opcode == OPC_OP32) && reg32_ok;
   assign is_arith    = is_op_imm || is_op || is_op_imm32 || is_op32;

   assign illegal = !(is_lui || is_auipc || is_jal || is_jalr || is_branch ||
                      is_load || is_store || is_arith);

   always_comb begin
      o_alu_op = ALU_OP_ADD;    // Addresses, AUIPC and JALR all go through the adder.
      if (is_lui) begin
         o_alu_op = ALU_OP_PASSB;
      end else if (is_arith) begin
         case (funct3)
            3'b000:  o_alu_op = ((is_op || is_op32) && i_insn[30]) ? ALU_OP_SUB : ALU_OP_ADD;
            3'b001:  o_alu_op = ALU_OP_SLL;
            3'b010:  o_alu_op = ALU_OP_SLT;
            3'b011:  o_alu_op = ALU_OP_SLTU;
            3'b100:  o_alu_op = ALU_OP_XOR;
            3'b101:  o_alu_op = i_insn[30] ? ALU_OP_SRA : ALU_OP_SRL;
            3'b110:  o_alu_op = ALU_OP_OR;
            default: o_alu_op = ALU_OP_AND;
         endcase
      end
   end

   always_comb begin
      if (is_op || is_op32 || is_branch) begin
         o_opb_sel = OPB_RF;
      end else if (is_lui || is_auipc) begin
         o_opb_sel = OPB_IMM20;
      end else if ((is_op_imm || is_op_imm32) && (funct3[1:0] == 2'b01)) begin
         o_opb_sel = OPB_SHAMT;
      end else begin
         o_opb_sel = OPB_IMM12;
      end
   end

   assign o_rs1_addr   = i_insn[19:15];
   assign o_rs2_addr   = i_insn[24:20];
   assign o_rd         = i_insn[11:7];
   assign o_illegal    = illegal;
   assign o_rf_we      = !illegal && !is_store && !is_branch;
   assign o_opa_pc     = is_auipc;
   assign o_word       = is_op_imm32 || is_op32;
   assign o_lsu_load   = is_load;
   assign o_lsu_store  = is_store;
   assign o_lsu_sigext = !funct3[2];
   assign o_lsu_size   = 4'd1 << funct3[1:0];  // 1, 2, 4 or 8 bytes.
   assign o_branch     = is_branch;
   assign o_br_cond    = funct3;
   assign o_jal        = is_jal;
   assign o_jalr       = is_jalr;

   assign o_imm12 = is_store ? {i_insn[31:25], i_insn[11:7]} : i_insn[31:20];
   assign o_imm13 = {i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
   assign o_imm21 = {i_insn[31], i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
   assign o_imm20 = i_insn[31:12];
   assign o_shamt = i_insn[25:20];

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
   input  logic              i_clk,
   input  logic              i_reset,
   input  rv_pkg::reg_addr_t i_rs1_addr,
   input  rv_pkg::reg_addr_t i_rs2_addr,
   input  rv_pkg::reg_addr_t i_rd,
   input  logic              i_we,
   input  rv_pkg::xlen_t     i_wdata,
   output rv_pkg::xlen_t     o_rs1_data,
   output rv_pkg::xlen_t     o_rs2_data
);
   import rv_pkg::*;

   xlen_t regs [1:31];    // There is no storage behind x0.

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && (i_rd != '0)) begin
         regs[i_rd] <= i_wdata;
      end
   end

   assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
   assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

/* hdl/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
   input  rv_pkg::alu_op_t i_op,
   input  logic            i_word,
   input  rv_pkg::xlen_t   i_a,
   input  rv_pkg::xlen_t   i_b,
   input  logic [2:0]      i_br_cond,
   input  rv_pkg::xlen_t   i_rs1,
   input  rv_pkg::xlen_t   i_rs2,
   output rv_pkg::xlen_t   o_result,
   output logic            o_br_true
);
   import rv_pkg::*;

   logic [5:0] shamt;
   xlen_t      a_srl;
   xlen_t      a_sra;
   xlen_t      raw;
   logic       br_eq;
   logic       br_lt;
   logic       br_ltu;

   // Word shifts see only the low 32 bits, extended the way the shift needs.
   assign shamt = i_word ? {1'b0, i_b[4:0]} : i_b[5:0];
   assign a_srl = i_word ? {32'b0, i_a[31:0]} : i_a;
   assign a_sra = i_word ? {{32{i_a[31]}}, i_a[31:0]} : i_a;

   always_comb begin
      case (i_op)
         ALU_OP_ADD:   raw = i_a + i_b;
         ALU_OP_SUB:   raw = i_a - i_b;
         ALU_OP_SLL:   raw = i_a << shamt;
         ALU_OP_SLT:   raw = {{(XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
         ALU_OP_SLTU:  raw = {{(XLEN-1){1'b0}}, i_a < i_b};
         ALU_OP_XOR:   raw = i_a ^ i_b;
         ALU_OP_SRL:   raw = a_srl >> shamt;
         ALU_OP_SRA:   raw = $signed(a_sra) >>> shamt;
         ALU_OP_OR:    raw = i_a | i_b;
         ALU_OP_AND:   raw = i_a & i_b;
         ALU_OP_PASSB: raw = i_b;
         default:      raw = '0;
      endcase
   end

   assign o_result = i_word ? {{32{raw[31]}}, raw[31:0]} : raw;  // W results sign-extend bit 31.

   assign br_eq  = (i_rs1 == i_rs2);
   assign br_lt  = ($signed(i_rs1) < $signed(i_rs2));
   assign br_ltu = (i_rs1 < i_rs2);

   always_comb begin
      case (i_br_cond)
         3'b000:  o_br_true = br_eq;
         3'b001:  o_br_true = !br_eq;
         3'b100:  o_br_true = br_lt;
         3'b101:  o_br_true = !br_lt;
         3'b110:  o_br_true = br_ltu;
         3'b111:  o_br_true = !br_ltu;
         default: o_br_true = 1'b0;
      endcase
   end

endmodule

/* hdl/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu (
   input  logic               i_clk,
   input  logic               i_load,
   input  logic               i_store,
   input  logic               i_sigext,
   input  rv_pkg::lsu_size_t  i_size,
   input  rv_pkg::dmem_addr_t i_addr,
   input  rv_pkg::xlen_t      i_wdata,
   input  logic               i_commit,
   output rv_pkg::xlen_t      o_rdata
);
   import rv_pkg::*;

   logic [7:0] mem [DMEM_BYTES];
   dmem_addr_t byte_addr [8];     // Wraps around at the top of the array.
   xlen_t      gathered;

   always_comb begin
      for (int b = 0; b < 8; b++) begin
         byte_addr[b] = i_addr + dmem_addr_t'(b);
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_commit && i_store) begin
         for (int b = 0; b < 8; b++) begin
            if (b < int'(i_size)) begin
               mem[byte_addr[b]] <= i_wdata[8*b +: 8];   // Little-endian byte lanes.
            end
         end
      end
   end

   always_comb begin
      gathered = '0;
      for (int b = 0; b < 8; b++) begin
         if (b < int'(i_size)) begin
            gathered[8*b +: 8] = mem[byte_addr[b]];
         end
      end
   end

   always_comb begin
      case (i_size)
         4'd1:    o_rdata = {{56{i_sigext & gathered[7]}}, gathered[7:0]};
         4'd2:    o_rdata = {{48{i_sigext & gathered[15]}}, gathered[15:0]};
         4'd4:    o_rdata = {{32{i_sigext & gathered[31]}}, gathered[31:0]};
         default: o_rdata = gathered;
      endcase
      if (!i_load) begin
         o_rdata = '0;
      end
   end

endmodule

/* hdl/rv_exu.sv */
`timescale 1ns/1ps

module rv_exu (
   input  logic              i_clk,
   input  logic              i_reset,
   input  logic              i_req,
   input  rv_pkg::xlen_t     i_pc,
   input  rv_pkg::insn_t     i_insn,
   output logic              o_ack,
   output logic              o_rd_we,
   output rv_pkg::reg_addr_t o_rd,
   output rv_pkg::xlen_t     o_rd_data,
   output rv_pkg::xlen_t     o_next_pc,
   output logic              o_illegal
);
   import rv_pkg::*;

   exu_state_t  state;
   xlen_t       pc_q;
   insn_t       insn_q;
   reg_addr_t   rs1_addr;
   reg_addr_t   rs2_addr;
   reg_addr_t   rd;
   logic        rf_we;
   logic        illegal;
   alu_op_t     alu_op;
   opb_sel_t    opb_sel;
   logic        opa_pc;
   logic        word;
   logic        lsu_load;
   logic        lsu_store;
   logic        lsu_sigext;
   lsu_size_t   lsu_size;
   logic        branch;
   logic [2:0]  br_cond;
   logic        jal;
   logic        jalr;
   logic [11:0] imm12;
   logic [12:0] imm13;
   logic [20:0] imm21;
   logic [19:0] imm20;
   logic [5:0]  shamt;
   xlen_t       rs1_data;
   xlen_t       rs2_data;
   xlen_t       opa;
   xlen_t       opb;
   xlen_t       alu_result;
   logic        br_true;
   xlen_t       lsu_rdata;
   xlen_t       pc_plus4;
   xlen_t       next_pc;
   xlen_t       wb_data;
   logic        commit;
   logic        wb_en;

   rv_idu u_idu (
      .i_insn(insn_q), .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_rd(rd),
      .o_rf_we(rf_we), .o_illegal(illegal), .o_alu_op(alu_op), .o_opb_sel(opb_sel),
      .o_opa_pc(opa_pc), .o_word(word), .o_lsu_load(lsu_load), .o_lsu_store(lsu_store),
      .o_lsu_sigext(lsu_sigext), .o_lsu_size(lsu_size), .o_branch(branch),
      .o_br_cond(br_cond), .o_jal(jal), .o_jalr(jalr), .o_imm12(imm12), .o_imm13(imm13),
      .o_imm21(imm21), .o_imm20(imm20), .o_shamt(shamt)
   );

   rv_regfile u_regfile (
      .i_clk(i_clk), .i_reset(i_reset), .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
      .i_rd(rd), .i_we(commit && wb_en), .i_wdata(wb_data),
      .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
   );

   assign opa = opa_pc ? pc_q : rs1_data;

   always_comb begin
      case (opb_sel)
         OPB_RF:    opb = rs2_data;
         OPB_IMM12: opb = {{52{imm12[11]}}, imm12};
         OPB_IMM20: opb = {{32{imm20[19]}}, imm20, 12'b0};
         OPB_SHAMT: opb = {58'b0, shamt};
         default:   opb = '0;
      endcase
   end

   rv_alu u_alu (
      .i_op(alu_op), .i_word(word), .i_a(opa), .i_b(opb), .i_br_cond(br_cond),
      .i_rs1(rs1_data), .i_rs2(rs2_data), .o_result(alu_result), .o_br_true(br_true)
   );

   rv_lsu u_lsu (
      .i_clk(i_clk), .i_load(lsu_load), .i_store(lsu_store), .i_sigext(lsu_sigext),
      .i_size(lsu_size), .i_addr(alu_result[7:0]), .i_wdata(rs2_data),
      .i_commit(commit), .o_rdata(lsu_rdata)
   );

   assign commit   = (state == EXEC);
   assign wb_en    = rf_we && (rd != '0);  // Illegal words and x0 targets write nothing.
   assign pc_plus4 = pc_q + 64'd4;
   assign wb_data  = lsu_load ? lsu_rdata : (jal || jalr) ? pc_plus4 : alu_result;

   always_comb begin
      if (jal) begin
         next_pc = pc_q + {{43{imm21[20]}}, imm21};
      end else if (jalr) begin
         next_pc = {alu_result[XLEN-1:1], 1'b0};
      end else if (branch && br_true) begin
         next_pc = pc_q + {{51{imm13[12]}}, imm13};
      end else begin
         next_pc = pc_plus4;
      end
   end

   always_ff @(posedge i_clk) begin
      if ((state == IDLE) && i_req) begin
         pc_q   <= i_pc;
         insn_q <= i_insn;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state     <= IDLE;
         o_rd_we   <= 1'b0;
         o_rd      <= '0;
         o_rd_data <= '0;
         o_next_pc <= '0;
         o_illegal <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (i_req) begin
                  state <= EXEC;
               end
            end
            EXEC: begin
               state     <= ACK;
               o_rd_we   <= wb_en;
               o_rd      <= rd;
               o_rd_data <= wb_en ? wb_data : '0;
               o_next_pc <= next_pc;
               o_illegal <= illegal;
            end
            ACK: begin
               if (!i_req) begin
                  state <= IDLE;      // Results hold until the requester lets go.
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   assign o_ack = (state == ACK);

endmodule

/* verif/rv_exu_assertions.sv */
`timescale 1ns/1ps

module rv_exu_assertions (
   input logic              i_clk,
   input logic              i_reset,
   input logic              i_req,
   input logic              i_ack,
   input logic              i_rd_we,
   input rv_pkg::reg_addr_t i_rd,
   input rv_pkg::xlen_t     i_rd_data,
   input rv_pkg::xlen_t     i_next_pc,
   input logic              i_illegal
);

   ack_rise: assert property (@(posedge i_clk) disable iff (i_reset)
      $rose(i_ack) |-> $past(i_req))
      else $error("o_ack rose without a request");

   ack_fall: assert property (@(posedge i_clk) disable iff (i_reset)
      $fell(i_ack) |-> !$past(i_req))
      else $error("o_ack fell while the request was still high");

   // Results are frozen for as long as the acknowledge is up.
   hold_stable: assert property (@(posedge i_clk) disable iff (i_reset)
      (i_ack && $past(i_ack)) |-> ($stable(i_rd_we) && $stable(i_rd) &&
         $stable(i_rd_data) && $stable(i_next_pc) && $stable(i_illegal)))
      else $error("results changed while o_ack was high");

   illegal_no_write: assert property (@(posedge i_clk) disable iff (i_reset)
      !(i_illegal && i_rd_we))
      else $error("illegal instruction reported a register write");

endmodule

bind rv_exu rv_exu_assertions u_assertions (
   .i_clk(i_clk), .i_reset(i_reset), .i_req(i_req), .i_ack(o_ack), .i_rd_we(o_rd_we),
   .i_rd(o_rd), .i_rd_data(o_rd_data), .i_next_pc(o_next_pc), .i_illegal(o_illegal)
);

/* verif/tb_rv_exu.sv */
`timescale 1ns/1ps

module tb_rv_exu;
   import rv_pkg::*;

   localparam int NUM_INSNS    = 44;
   localparam int FIELDS       = 7;
   localparam int ACK_TIMEOUT  = 50;
   localparam logic [63:0] SEED = 64'd92;

   logic        i_clk;
   logic        i_reset;
   logic        i_req;
   xlen_t       i_pc;
   insn_t       i_insn;
   logic        o_ack;
   logic        o_rd_we;
   reg_addr_t   o_rd;
   xlen_t       o_rd_data;
   xlen_t       o_next_pc;
   logic        o_illegal;

   logic [63:0] gold [NUM_INSNS*FIELDS];
   logic [63:0] rng_state;
   int          ack_count;
   logic        ack_q;

   rv_exu uut (
      .i_clk(i_clk), .i_reset(i_reset), .i_req(i_req), .i_pc(i_pc), .i_insn(i_insn),
      .o_ack(o_ack), .o_rd_we(o_rd_we), .o_rd(o_rd), .o_rd_data(o_rd_data),
      .o_next_pc(o_next_pc), .o_illegal(o_illegal)
   );

   initial begin
      i_clk = 1'b0;
      forever begin
         #4 i_clk = ~i_clk;
      end
   end

   // Counts rising edges of o_ack, one per completed instruction.
   always @(negedge i_clk) begin
      if (i_reset) begin
         ack_count <= 0;
      end else if (o_ack && !ack_q) begin
         ack_count <= ack_count + 1;
      end
      ack_q <= o_ack;
   end

   function automatic logic [63:0] xorshift(input logic [63:0] s);
      logic [63:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 7);
      x = x ^ (x << 17);
      return x;
   endfunction

   function automatic int next_gap();
      rng_state = xorshift(rng_state);
      return int'(rng_state[1:0]);   // Zero to three idle cycles.
   endfunction

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAIL %0d ns %s got %h expected %h", $time, name, got, exp);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   endtask

   task automatic check_outputs(input int idx);
      int base;
      base = idx * FIELDS;
      compare("rd_we", {63'b0, o_rd_we}, gold[base+2]);
      compare("rd", {59'b0, o_rd}, gold[base+3]);
      compare("rd_data", o_rd_data, gold[base+4]);
      compare("next_pc", o_next_pc, gold[base+5]);
      compare("illegal", {63'b0, o_illegal}, gold[base+6]);
   endtask

   task automatic run_one(input int idx);
      int gap;
      int wait_cycles;
      gap = next_gap();
      repeat (gap) @(posedge i_clk);
      @(posedge i_clk);
      i_req  <= 1'b1;
      i_pc   <= gold[idx*FIELDS];
      i_insn <= gold[idx*FIELDS+1][31:0];
      wait_cycles = 0;
      @(negedge i_clk);
      while (!o_ack) begin
         if (wait_cycles >= ACK_TIMEOUT) begin
            $display("Timeout: o_ack never rose for instruction %0d", idx);
            $display("ERRORS FOUND");
            $fatal(1);
         end
         wait_cycles++;
         @(negedge i_clk);
      end
      check_outputs(idx);
      // Holding i_req high must leave the results untouched.
      gap = next_gap();
      repeat (gap) begin
         @(negedge i_clk);
         compare("ack_held", {63'b0, o_ack}, 64'd1);
         check_outputs(idx);
      end
      @(posedge i_clk);
      i_req <= 1'b0;
      wait_cycles = 0;
      @(negedge i_clk);
      while (o_ack) begin
         if (wait_cycles >= ACK_TIMEOUT) begin
            $display("Timeout: o_ack never fell for instruction %0d", idx);
            $display("ERRORS FOUND");
            $fatal(1);
         end
         wait_cycles++;
         @(negedge i_clk);
      end
   endtask

   initial begin
      i_reset     = 1'b1;
      i_req       = 1'b0;
      i_pc        = '0;
      i_insn      = '0;
      ack_q       = 1'b0;
      ack_count   = 0;
      rng_state   = SEED;
      $readmemh("verif/rv_exu_golden.txt", gold);
      repeat (5) @(posedge i_clk);
      i_reset <= 1'b0;
      for (int i = 0; i < NUM_INSNS; i++) begin
         run_one(i);
      end
      @(negedge i_clk);
      compare("ack_count", 64'(ack_count), 64'(NUM_INSNS));
      $display("NO ERRORS");
      $finish;
   end

endmodule

/* verif/rv_exu_golden.txt */
// pc insn rd_we rd rd_data next_pc illegal (all hex)
// Stores precede the loads that read them back.
1000 00500093 1 01 0000000000000005 1004 0
1004 FFD00113 1 02 FFFFFFFFFFFFFFFD 1008 0
1008 002081B3 1 03 0000000000000002 100C 0
100C 40208233 1 04 0000000000000008 1010 0
1010 001122B3 1 05 0000000000000001 1014 0
1014 00113333 1 06 0000000000000000 1018 0
1018 0F014393 1 07 FFFFFFFFFFFFFF0D 101C 0
101C 02809413 1 08 0000050000000000 1020 0
1020 40115493 1 09 FFFFFFFFFFFFFFFE 1024 0
1024 80000537 1 0A FFFFFFFF80000000 1028 0
1028 00001597 1 0B 0000000000002028 102C 0
102C FFF5061B 1 0C 000000007FFFFFFF 1030 0
1030 001606BB 1 0D FFFFFFFF80000004 1034 0
1034 01F0971B 1 0E FFFFFFFF80000000 1038 0
1038 41F6D79B 1 0F FFFFFFFFFFFFFFFF 103C 0
103C 01F6D81B 1 10 0000000000000001 1040 0
1040 00D03823 0 10 0000000000000000 1044 0
1044 00100C23 0 18 0000000000000000 1048 0
1048 00201D23 0 1A 0000000000000000 104C 0
104C 00C02E23 0 1C 0000000000000000 1050 0
1050 01003883 1 11 FFFFFFFF80000004 1054 0
1054 01002903 1 12 FFFFFFFF80000004 1058 0
1058 01006983 1 13 0000000080000004 105C 0
105C 01300A03 1 14 FFFFFFFFFFFFFF80 1060 0
1060 01804A83 1 15 0000000000000005 1064 0
1064 01A01B03 1 16 FFFFFFFFFFFFFFFD 1068 0
1068 01A05B83 1 17 000000000000FFFD 106C 0
106C 01C02C03 1 18 000000007FFFFFFF 1070 0
1070 00108863 0 10 0000000000000000 1080 0
1074 00109863 0 10 0000000000000000 1078 0
1078 FE114CE3 0 19 0000000000000000 1070 0
107C FE115CE3 0 19 0000000000000000 1080 0
1080 0020E463 0 08 0000000000000000 1088 0
1084 0020F463 0 08 0000000000000000 1088 0
1088 10000CEF 1 19 000000000000108C 1188 0
108C 00708D67 1 1A 0000000000001090 000C 0
1090 00908013 0 00 0000000000000000 1094 0
1094 00100DB3 1 1B 0000000000000005 1098 0
1098 FFFFFFFF 0 1F 0000000000000000 109C 1
109C 00000073 0 00 0000000000000000 10A0 1
10A0 00A17E33 1 1C FFFFFFFF80000000 10A4 0
10A4 00E0EEB3 1 1D FFFFFFFF80000005 10A8 0
10A8 4016DF33 1 1E FFFFFFFFFC000000 10AC 0
10AC 00115FB3 1 1F 07FFFFFFFFFFFFFF 10B0 0

/* files.f */
hdl/rv_pkg.sv
hdl/rv_idu.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_lsu.sv
hdl/rv_exu.sv
verif/rv_exu_assertions.sv
verif/tb_rv_exu.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module tb_rv_exu -f files.f

run: build
	./obj_dir/Vtb_rv_exu | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "NO ERRORS" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module tb_rv_exu -f files.f
	verilator --lint-only -Wall --top-module rv_exu hdl/rv_pkg.sv hdl/rv_idu.sv \
		hdl/rv_regfile.sv hdl/rv_alu.sv hdl/rv_lsu.sv hdl/rv_exu.sv

clean:
	rm -rf obj_dir sim.log
